// ==== files.f ====
verilog/pdm_pkg.sv
verilog/cic_decimator.sv
verilog/non_restoring_divider.sv
verilog/post_processor.sv
verilog/pdm_to_pcm_top.sv
verification/pdm_to_pcm_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the pdm to pcm testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

rm -rf "$BUILD" "$LOG"

verilator --binary --timing -f files.f --top-module pdm_to_pcm_tb \
    -Mdir "$BUILD" -o pdm_to_pcm_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$BUILD/pdm_to_pcm_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== verification/pdm_to_pcm_tb.sv ====
`timescale 1ns/1ps

module pdm_to_pcm_tb;

    import pdm_pkg::*;

    localparam int SEED        = 19777;
    localparam int HALF_PERIOD = 2;          // 4 ns clock
    localparam int DRIVE_DELAY = 1;          // inputs change 1 ns after the rising edge
    localparam int LATENCY     = 35;         // completing strobe to pcm_valid_o
    localparam int WATCHDOG_NS = 1000000;

    logic   clk_i;
    logic   rst_n_i;
    logic   pdm_valid_i;
    logic   pdm_bit_i;
    decim_t decim_i;
    logic   signed_i;
    pcm_t   pcm_o;
    logic   pcm_valid_o;
    logic   invalid_o;

    int          cycle_cnt;
    logic [31:0] lcg_state;
    int          value_errors;
    int          flag_errors;
    int          latency_errors;
    int          protocol_errors;
    int          invalid_seen;               // invalid_o pulses counted in zero mode
    logic        zero_mode;                  // gain is zero so no samples are expected
    pcm_t        last_pcm;

    // model state of the filter
    code_t mdl_i1;
    code_t mdl_i2;
    code_t mdl_c1d;
    code_t mdl_c2d;
    code_t mdl_gain;
    int    mdl_count;
    int    mdl_decim;
    logic  mdl_signed;
    pcm_t  exp_pcm_q[$];                     // expected samples in arrival order
    int    exp_cyc_q[$];                     // cycle of the completing strobe

    pdm_to_pcm_top u_dut (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .pdm_valid_i ( pdm_valid_i ),
        .pdm_bit_i   ( pdm_bit_i   ),
        .decim_i     ( decim_i     ),
        .signed_i    ( signed_i    ),
        .pcm_o       ( pcm_o       ),
        .pcm_valid_o ( pcm_valid_o ),
        .invalid_o   ( invalid_o   )
    );

    always #(HALF_PERIOD) clk_i = ~clk_i;

    // read only off the edge, at the drive point and the falling edge
    always @(posedge clk_i) cycle_cnt = cycle_cnt + 1;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // q = floor(code * 65536 / gain) is clamped and then shifted by the midpoint if signed
    function automatic pcm_t expected_pcm(input code_t code, input code_t gain, input logic sgn);
        longint q;
        q = (longint'(code) * longint'(65536)) / longint'(gain);
        if (q > longint'(65535)) q = longint'(65535);
        if (sgn) begin
            q = q - longint'(32768);
            if (q < 0) q = q + longint'(65536);       // modulo 2^16
        end
        return pcm_t'(q);
    endfunction

    // two integrators per bit and two combs at the block end
    function automatic void predict_bit(input logic b);
        code_t c1;
        code_t c2;
        mdl_i1 = mdl_i1 + code_t'(b);
        mdl_i2 = mdl_i2 + mdl_i1;
        if (mdl_count + 1 >= mdl_decim) begin
            c1        = mdl_i2 - mdl_c1d;
            c2        = c1 - mdl_c2d;
            mdl_c1d   = mdl_i2;
            mdl_c2d   = c1;
            mdl_count = 0;
            exp_pcm_q.push_back(expected_pcm(c2, mdl_gain, mdl_signed));
            exp_cyc_q.push_back(cycle_cnt);
        end else begin
            mdl_count++;
        end
    endfunction

    task automatic check_pcm(input pcm_t actual, input pcm_t expected);
        if (actual !== expected) begin
            value_errors++;
            $display("[ERROR] %0t pcm_o: got %h expected %h", $time, actual, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            flag_errors++;
            $display("[ERROR] %0t %s: got %b expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic check_latency(input int actual, input int expected);
        if (actual != expected) begin
            latency_errors++;
            $display("[ERROR] %0t pcm_valid_o latency: got %0d expected %0d",
                     $time, actual, expected);
        end
    endtask

    task automatic step_to_drive();
        @(posedge clk_i);
        #(DRIVE_DELAY);
    endtask

    // a change clears the filter and the gain follows two cycles later
    task automatic set_factor(input int r);
        step_to_drive();
        decim_i     = decim_t'(r);
        pdm_valid_i = 1'b0;
        mdl_decim   = r;
        mdl_gain    = code_t'(r * r);
        mdl_i1      = '0;
        mdl_i2      = '0;
        mdl_c1d     = '0;
        mdl_c2d     = '0;
        mdl_count   = 0;
        repeat (3) step_to_drive();             // no strobes until the new gain is in
    endtask

    task automatic set_mode(input logic s);
        step_to_drive();
        signed_i   = s;
        mdl_signed = s;
    endtask

    task automatic run_stream(input int nbits, input logic random_bits, input logic level);
        logic [31:0] r;
        logic [15:0] density;
        int          sent;
        r       = next_random();
        density = r[31:16];
        sent    = 0;
        while (sent < nbits) begin
            step_to_drive();
            r = next_random();
            if (random_bits && r[31:29] == 3'd0) begin
                pdm_valid_i = 1'b0;              // gap where the counter must hold
            end else begin
                pdm_valid_i = 1'b1;
                pdm_bit_i   = random_bits ? (r[27:12] < density) : level;
                predict_bit(pdm_bit_i);
                sent++;
            end
        end
        step_to_drive();
        pdm_valid_i = 1'b0;
    endtask

    task automatic drain_samples(input int timeout);
        int n;
        n = 0;
        while (exp_pcm_q.size() != 0 && n < timeout) begin
            @(posedge clk_i);
            n++;
        end
        if (exp_pcm_q.size() != 0) begin
            protocol_errors++;
            $display("timed out with %0d samples still pending", exp_pcm_q.size());
        end
    endtask

    task automatic wait_invalid(input int timeout);
        logic [31:0] r;
        int          n;
        n = 0;
        while (invalid_seen == 0 && n < timeout) begin
            step_to_drive();
            r           = next_random();
            pdm_valid_i = 1'b1;
            pdm_bit_i   = r[20];
            n++;
        end
        step_to_drive();
        pdm_valid_i = 1'b0;
        if (invalid_seen == 0) begin
            protocol_errors++;
            $display("invalid_o never pulsed with a zero decimation factor");
        end
    endtask

    // divider finishes within 34 cycles, so 40 silent cycles means it is drained
    task automatic wait_quiet(input int quiet, input int timeout);
        int n;
        int q;
        n = 0;
        q = 0;
        while (q < quiet && n < timeout) begin
            @(negedge clk_i);
            if (pcm_valid_o || invalid_o) q = 0;
            else q++;
            n++;
        end
        if (q < quiet) begin
            protocol_errors++;
            $display("output strobes did not stop after the input went quiet");
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            check_flag("pcm_valid_o", pcm_valid_o, 1'b0);
            check_flag("invalid_o", invalid_o, 1'b0);
        end else begin
            if (pcm_valid_o) begin
                if (zero_mode) begin
                    protocol_errors++;
                    $display("pcm_valid_o pulsed while the gain was zero at %0t", $time);
                end else if (exp_pcm_q.size() == 0) begin
                    protocol_errors++;
                    $display("pcm_valid_o pulsed with no sample pending at %0t", $time);
                end else begin
                    check_latency(cycle_cnt - exp_cyc_q[0], LATENCY);
                    check_pcm(pcm_o, exp_pcm_q.pop_front());
                    void'(exp_cyc_q.pop_front());
                    last_pcm = pcm_o;
                end
            end else if (exp_cyc_q.size() != 0 && cycle_cnt - exp_cyc_q[0] > LATENCY) begin
                protocol_errors++;
                $display("expected pcm_valid_o did not arrive by %0t", $time);
                void'(exp_pcm_q.pop_front());
                void'(exp_cyc_q.pop_front());
            end
            if (zero_mode) begin
                if (invalid_o) invalid_seen++;
            end else begin
                check_flag("invalid_o", invalid_o, 1'b0);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("simulation ran past its time limit");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        clk_i           = 1'b0;
        rst_n_i         = 1'b0;
        pdm_valid_i     = 1'b0;
        pdm_bit_i       = 1'b0;
        decim_i         = '0;
        signed_i        = 1'b0;
        cycle_cnt       = 0;
        lcg_state       = 32'(SEED);
        value_errors    = 0;
        flag_errors     = 0;
        latency_errors  = 0;
        protocol_errors = 0;
        invalid_seen    = 0;
        zero_mode       = 1'b0;
        last_pcm        = '0;
        mdl_signed      = 1'b0;

        repeat (10) @(posedge clk_i);       // reset with the flags checked by the monitor
        #(DRIVE_DELAY);
        rst_n_i = 1'b1;

        // unsigned and then the same stream signed
        set_factor(64);
        run_stream(64 * 16, 1'b1, 1'b0);
        drain_samples(200);
        lcg_state = 32'(SEED);
        set_mode(1'b1);
        run_stream(64 * 16, 1'b1, 1'b0);
        drain_samples(200);

        // full scale and silence at R = 50
        set_factor(50);
        set_mode(1'b0);
        run_stream(50 * 4, 1'b0, 1'b1);
        drain_samples(200);
        check_pcm(last_pcm, 16'hFFFF);
        set_mode(1'b1);
        run_stream(50 * 2, 1'b0, 1'b1);
        drain_samples(200);
        check_pcm(last_pcm, 16'h7FFF);
        set_mode(1'b0);
        run_stream(50 * 4, 1'b0, 1'b0);
        drain_samples(200);
        check_pcm(last_pcm, 16'h0000);
        set_mode(1'b1);
        run_stream(50 * 2, 1'b0, 1'b0);
        drain_samples(200);
        check_pcm(last_pcm, 16'h8000);

        // factor change in the middle of a block
        set_mode(1'b0);
        set_factor(64);
        run_stream(64 * 3 + 17, 1'b1, 1'b0);
        drain_samples(200);
        set_factor(100);
        run_stream(100 * 6, 1'b1, 1'b0);
        drain_samples(200);

        // zero gain and then back to normal operation
        set_factor(0);
        zero_mode = 1'b1;
        wait_invalid(300);
        wait_quiet(40, 400);
        zero_mode = 1'b0;
        set_factor(64);
        run_stream(64 * 8, 1'b1, 1'b0);
        drain_samples(200);

        $display("errors: value %0d, flag %0d, latency %0d, protocol %0d",
                 value_errors, flag_errors, latency_errors, protocol_errors);
        if (value_errors + flag_errors + latency_errors + protocol_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : pdm_to_pcm_tb

// ==== verilog/cic_decimator.sv ====
`timescale 1ns/1ps

module cic_decimator (
    input  logic            clk_i,
    input  logic            rst_n_i,

    // pdm stream, one strobe per bit
    input  logic            pdm_valid_i,
    input  logic            pdm_bit_i,

    input  pdm_pkg::decim_t decim_i,        // decimation factor R

    output pdm_pkg::code_t  code_o,         // comb output, valid with code_valid_o
    output logic            code_valid_o,
    output pdm_pkg::code_t  gain_o          // full scale of the filter, R squared
);

    import pdm_pkg::*;

    // second order filter, all arithmetic wraps at 16 bits
    code_t  integ1_q;
    code_t  integ2_q;
    code_t  integ1_next;
    code_t  integ2_next;
    code_t  comb1_dly_q;                    // integrator 2 at the previous block end
    code_t  comb2_dly_q;                    // comb 1 at the previous block end
    code_t  comb1;
    code_t  comb2;

    decim_t               decim_q;          // registered factor, change detection
    decim_t               count_q;          // strobes seen in the current block
    logic [DECIM_WIDTH:0] count_inc;        // one extra bit so R = 255 compares cleanly
    logic                 block_done;
    logic                 factor_change;
    logic                 gain_reload_q;

    assign factor_change = (decim_i != decim_q);

    // integrators see the incoming bit in the same cycle, no pipeline between them
    assign integ1_next = integ1_q + code_t'(pdm_bit_i);
    assign integ2_next = integ2_q + integ1_next;

    // combs evaluated on the updated integrator so the completing bit is included
    assign comb1 = integ2_next - comb1_dly_q;
    assign comb2 = comb1 - comb2_dly_q;

    assign count_inc  = {1'b0, count_q} + 1'b1;
    assign block_done = (count_inc >= {1'b0, decim_q});     // R = 0 fires on every strobe

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            integ1_q      <= '0;
            integ2_q      <= '0;
            comb1_dly_q   <= '0;
            comb2_dly_q   <= '0;
            count_q       <= '0;
            decim_q       <= '0;
            gain_reload_q <= 1'b0;
            gain_o        <= '0;
            code_valid_o  <= 1'b0;
        end else begin
            decim_q       <= decim_i;
            gain_reload_q <= factor_change;     // gain follows one cycle after the change
            code_valid_o  <= 1'b0;

            if (gain_reload_q) begin
                gain_o <= code_t'(decim_q) * code_t'(decim_q);
            end

            if (factor_change) begin
                // restart the filter, the next code covers a fresh block
                integ1_q    <= '0;
                integ2_q    <= '0;
                comb1_dly_q <= '0;
                comb2_dly_q <= '0;
                count_q     <= '0;
            end else if (pdm_valid_i) begin
                integ1_q <= integ1_next;
                integ2_q <= integ2_next;
                if (block_done) begin
                    count_q      <= '0;
                    comb1_dly_q  <= integ2_next;
                    comb2_dly_q  <= comb1;
                    code_valid_o <= 1'b1;
                end else begin
                    count_q <= count_inc[DECIM_WIDTH-1:0];
                end
            end
        end
    end

    // code word only, qualified by code_valid_o
    always_ff @(posedge clk_i) begin
        if (pdm_valid_i && block_done && !factor_change) begin
            code_o <= comb2;
        end
    end

endmodule : cic_decimator

// ==== verilog/non_restoring_divider.sv ====
`timescale 1ns/1ps

module non_restoring_divider #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  clk_en_i,         // stalls the whole divider when low

    input  logic [DATA_WIDTH-1:0] dividend_i,
    input  logic [DATA_WIDTH-1:0] divisor_i,
    input  logic                  data_valid_i,     // start, ignored unless idle

    output logic [DATA_WIDTH-1:0] quotient_o,
    output logic [DATA_WIDTH-1:0] remainder_o,
    output logic                  divide_by_zero_o, // meaningful with data_valid_o
    output logic                  data_valid_o,     // one cycle, result ready
    output logic                  idle_o
);

    import pdm_pkg::*;

    localparam int CNT_WIDTH = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;

    div_state_t            state_q;
    logic [CNT_WIDTH-1:0]  iter_q;          // remaining steps, counts down to zero

    // partial remainder carries one extra sign bit
    logic [DATA_WIDTH:0]   rem_q;
    logic [DATA_WIDTH-1:0] quo_q;           // dividend bits shift out, quotient bits shift in
    logic [DATA_WIDTH-1:0] divisor_q;

    logic [DATA_WIDTH:0]   divisor_ext;
    logic [DATA_WIDTH:0]   rem_shift;
    logic [DATA_WIDTH:0]   rem_step;
    logic                  start;

    assign start       = data_valid_i & idle_o;
    assign divisor_ext = {1'b0, divisor_q};

    // bring down the next dividend bit
    assign rem_shift = {rem_q[DATA_WIDTH-1:0], quo_q[DATA_WIDTH-1]};

    // negative remainder adds the divisor back instead of restoring first
    assign rem_step = rem_q[DATA_WIDTH] ? rem_shift + divisor_ext
                                        : rem_shift - divisor_ext;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q          <= DIV_IDLE;
            iter_q           <= '0;
            data_valid_o     <= 1'b0;
            divide_by_zero_o <= 1'b0;
        end else if (clk_en_i) begin
            data_valid_o <= 1'b0;
            case (state_q)
                DIV_IDLE: begin
                    if (start) begin
                        state_q          <= DIV_RUN;
                        iter_q           <= CNT_WIDTH'(DATA_WIDTH - 1);
                        divide_by_zero_o <= (divisor_i == '0);   // held until the next load
                    end
                end
                DIV_RUN: begin
                    if (iter_q == '0) begin
                        state_q <= DIV_DONE;
                    end else begin
                        iter_q <= iter_q - 1'b1;
                    end
                end
                DIV_DONE: begin
                    state_q      <= DIV_IDLE;
                    data_valid_o <= 1'b1;
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            case (state_q)
                DIV_IDLE: begin
                    if (start) begin
                        rem_q     <= '0;
                        quo_q     <= dividend_i;
                        divisor_q <= divisor_i;
                    end
                end
                DIV_RUN: begin
                    rem_q <= rem_step;
                    quo_q <= {quo_q[DATA_WIDTH-2:0], ~rem_step[DATA_WIDTH]};  // 1 when non negative
                end
                DIV_DONE: begin
                    // quotient is already exact, only the remainder needs fixing
                    if (rem_q[DATA_WIDTH]) begin
                        rem_q <= rem_q + divisor_ext;
                    end
                end
                default: ;
            endcase
        end
    end

    assign quotient_o  = quo_q;
    assign remainder_o = rem_q[DATA_WIDTH-1:0];

    // still busy during the result cycle
    assign idle_o = (state_q == DIV_IDLE) & ~data_valid_o;

endmodule : non_restoring_divider

// ==== verilog/pdm_pkg.sv ====
package pdm_pkg;

    // sample width, shared by filter codes, gain and pcm words
    localparam int PCM_WIDTH   = 16;

    localparam int DECIM_WIDTH = 8;              // decimation factor, R up to 255

    // divider works on code << 16 over the gain, so twice the sample width
    localparam int DIV_WIDTH   = 2 * PCM_WIDTH;

    typedef logic [PCM_WIDTH-1:0]   pcm_t;       // output sample, signed or unsigned
    typedef logic [PCM_WIDTH-1:0]   code_t;      // cic code or full scale gain
    typedef logic [DECIM_WIDTH-1:0] decim_t;     // decimation factor
    typedef logic [DIV_WIDTH-1:0]   div_word_t;  // divider operand / result

    // divider control
    // idle  waits for a start strobe, operands latched on accept
    // run   one add/subtract and shift per cycle
    // done  final remainder correction
    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_t;

endpackage : pdm_pkg

// ==== verilog/pdm_to_pcm_top.sv ====
`timescale 1ns/1ps

module pdm_to_pcm_top (
    input  logic            clk_i,
    input  logic            rst_n_i,

    // pdm input, strobed per bit from outside
    input  logic            pdm_valid_i,
    input  logic            pdm_bit_i,

    input  pdm_pkg::decim_t decim_i,        // a change restarts the filter
    input  logic            signed_i,

    // pcm output, 35 cycles after the strobe that completes a block
    output pdm_pkg::pcm_t   pcm_o,
    output logic            pcm_valid_o,
    output logic            invalid_o       // pulses instead of pcm_valid_o when R = 0
);

    import pdm_pkg::*;

    code_t code;
    code_t gain;
    logic  code_valid;

    cic_decimator u_cic (
        .clk_i        ( clk_i       ),
        .rst_n_i      ( rst_n_i     ),
        .pdm_valid_i  ( pdm_valid_i ),
        .pdm_bit_i    ( pdm_bit_i   ),
        .decim_i      ( decim_i     ),
        .code_o       ( code        ),
        .code_valid_o ( code_valid  ),
        .gain_o       ( gain        )
    );

    // normalize by the gain, then map to pcm
    post_processor u_post (
        .clk_i        ( clk_i       ),
        .rst_n_i      ( rst_n_i     ),
        .code_i       ( code        ),
        .valid_i      ( code_valid  ),
        .normalizer_i ( gain        ),
        .signed_i     ( signed_i    ),
        .pcm_o        ( pcm_o       ),
        .valid_o      ( pcm_valid_o ),
        .invalid_o    ( invalid_o   )
    );

endmodule : pdm_to_pcm_top

// ==== verilog/post_processor.sv ====
`timescale 1ns/1ps

module post_processor (
    input  logic           clk_i,
    input  logic           rst_n_i,

    input  pdm_pkg::code_t code_i,          // cic code
    input  logic           valid_i,

    input  pdm_pkg::code_t normalizer_i,    // filter gain, full scale code

    input  logic           signed_i,        // 1 gives pcm centred on zero

    output pdm_pkg::pcm_t  pcm_o,
    output logic           valid_o,
    output logic           invalid_o        // gain was zero, no sample
);

    import pdm_pkg::*;

    div_word_t quotient;                    // q0.16 fraction, 65536 at full scale
    logic      div_done;
    logic      div_zero;
    logic      div_idle;
    pcm_t      sat_sample;

    // code / gain with the code shifted up by 16, a busy divider drops the code
    non_restoring_divider #(
        .DATA_WIDTH ( DIV_WIDTH )
    ) u_normalizer (
        .clk_i            ( clk_i                                 ),
        .rst_n_i          ( rst_n_i                               ),
        .clk_en_i         ( 1'b1                                  ),
        .dividend_i       ( {code_i, {PCM_WIDTH{1'b0}}}           ),
        .divisor_i        ( {{PCM_WIDTH{1'b0}}, normalizer_i}     ),
        .data_valid_i     ( valid_i & div_idle                    ),
        .quotient_o       ( quotient                              ),
        .remainder_o      (                                       ),
        .divide_by_zero_o ( div_zero                              ),
        .data_valid_o     ( div_done                              ),
        .idle_o           ( div_idle                              )
    );

    always_comb begin
        // code equal to gain gives exactly 1.0, clamp instead of wrapping to 0
        if (quotient[DIV_WIDTH-1:PCM_WIDTH] != '0) begin
            sat_sample = '1;
        end else begin
            sat_sample = quotient[PCM_WIDTH-1:0];
        end
        if (signed_i) begin
            pcm_o = sat_sample - pcm_t'(1 << (PCM_WIDTH - 1));  // shift by the midpoint
        end else begin
            pcm_o = sat_sample;
        end
    end

    assign valid_o   = div_done & ~div_zero;
    assign invalid_o = div_done &  div_zero;

endmodule : post_processor
